// ==== design/mul_defs.svh ====
// width macros for the packed multiply block
// lane count, lane width, register width and dot-sum width

`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// four lanes per source register
`define MUL_LANES 4

// one lane, product is twice this
`define LANE_WIDTH 16

// source and result register width
`define WORD_WIDTH 64

// dot sum of four lane products
// sized to match the separate multiply-accumulate chain
`define DOT_WIDTH 36

`endif

// ==== design/mulCmdPkg.sv ====
// request-side types for the packed multiply block
// operation enum, incoming request and staged command

`default_nettype none

`include "mul_defs.svh"

package mulCmdPkg;

	// result form, codes follow the execute-stage mode numbers
	// unlisted codes give a zero result
	typedef enum logic [2:0]
	{
		opLowWord  = 3'd1,
		opPairWord = 3'd3,
		opPackLow  = 3'd4,
		opPackHigh = 3'd5,
		opDotSum   = 3'd6
	} mulOp;

	// one request from the issue side, valid is a one-cycle strobe
	typedef struct packed
	{
		logic                   valid;
		mulOp                   op;
		logic                   isUnsigned;
		logic [`WORD_WIDTH-1:0] rs;
		logic [`WORD_WIDTH-1:0] rt;
	} mulReq;

	// control that travels next to the data through stage 1
	typedef struct packed
	{
		mulOp op;
		logic isUnsigned;
	} mulCmd;

endpackage

`default_nettype wire

// ==== design/mulResultPkg.sv ====
// result-side types for the packed multiply block
// per-lane products and the unit output

`default_nettype none

`include "mul_defs.svh"

package mulResultPkg;

	// four full-width lane products, lane 0 in the low bits
	typedef struct packed
	{
		logic [2*`LANE_WIDTH-1:0] prod3;
		logic [2*`LANE_WIDTH-1:0] prod2;
		logic [2*`LANE_WIDTH-1:0] prod1;
		logic [2*`LANE_WIDTH-1:0] prod0;
	} laneProd;

	// formatted result
	// valid strobes once per accepted request
	typedef struct packed
	{
		logic                   valid;
		logic [`WORD_WIDTH-1:0] value;
	} mulOut;

endpackage

`default_nettype wire

// ==== design/pipeStage.sv ====
// holdable register stage with a valid bit
// payload type is a parameter

`timescale 1ns/10ps
`default_nettype none

module pipeStage #(
	parameter type payloadT = logic
) (
	input  logic    clock,
	input  logic    rst,
	input  logic    hold,
	input  logic    inValid,
	input  payloadT inData,
	output logic    outValid,
	output payloadT outData
);

	// valid is the only control state here
	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (!hold)
			outValid <= inValid;
	end

	// payload just follows the stage, frozen by hold
	always_ff @(posedge clock)
	begin
		if (!hold)
			outData <= inData;
	end

endmodule

`default_nettype wire

// ==== design/laneProducts.sv ====
// per-lane 16x16 multipliers for the packed multiply block
// sign or zero extension per lane, products staged once

`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module laneProducts (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   hold,
	input  logic                   inValid,
	input  logic [`WORD_WIDTH-1:0] rs,
	input  logic [`WORD_WIDTH-1:0] rt,
	input  logic                   isUnsigned,
	output mulResultPkg::laneProd  products
);

	mulResultPkg::laneProd prodNext;

	// each lane is widened to 32 bits, then only the low 32 bits
	// of the product are kept; that is exact for 16x16 either way
	always_comb
	begin
		logic [`LANE_WIDTH-1:0]   rsLane;
		logic [`LANE_WIDTH-1:0]   rtLane;
		logic [2*`LANE_WIDTH-1:0] rsExt;
		logic [2*`LANE_WIDTH-1:0] rtExt;
		for (int lane = 0; lane < `MUL_LANES; lane++)
		begin
			rsLane = rs[lane*`LANE_WIDTH +: `LANE_WIDTH];
			rtLane = rt[lane*`LANE_WIDTH +: `LANE_WIDTH];
			// sign fill only for signed lanes
			rsExt = {{`LANE_WIDTH{rsLane[`LANE_WIDTH-1] & ~isUnsigned}}, rsLane};
			rtExt = {{`LANE_WIDTH{rtLane[`LANE_WIDTH-1] & ~isUnsigned}}, rtLane};
			prodNext[lane*2*`LANE_WIDTH +: 2*`LANE_WIDTH] = rsExt * rtExt;
		end
	end

	// stage valid is carried by the command stage in the top level
	pipeStage #(
		.payloadT(mulResultPkg::laneProd)
	) i_prodStage (
		.clock   (clock),
		.rst     (rst),
		.hold    (hold),
		.inValid (inValid),
		.inData  (prodNext),
		.outValid(),
		.outData (products)
	);

endmodule

`default_nettype wire

// ==== design/dotAccumulate.sv ====
// dot-product path of the packed multiply block
// own lane products summed into a 36-bit staged result

`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module dotAccumulate (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   hold,
	input  logic                   inValid,
	input  logic [`WORD_WIDTH-1:0] rs,
	input  logic [`WORD_WIDTH-1:0] rt,
	input  logic                   isUnsigned,
	output logic [`DOT_WIDTH-1:0]  dotSum
);

	logic [`DOT_WIDTH-1:0] sumNext;

	// separate multipliers, so the sum does not wait on the lane path
	always_comb
	begin
		logic [`LANE_WIDTH-1:0]   rsLane;
		logic [`LANE_WIDTH-1:0]   rtLane;
		logic [2*`LANE_WIDTH-1:0] rsExt;
		logic [2*`LANE_WIDTH-1:0] rtExt;
		logic [2*`LANE_WIDTH-1:0] prod;
		sumNext = '0;
		for (int lane = 0; lane < `MUL_LANES; lane++)
		begin
			rsLane = rs[lane*`LANE_WIDTH +: `LANE_WIDTH];
			rtLane = rt[lane*`LANE_WIDTH +: `LANE_WIDTH];
			rsExt = {{`LANE_WIDTH{rsLane[`LANE_WIDTH-1] & ~isUnsigned}}, rsLane};
			rtExt = {{`LANE_WIDTH{rtLane[`LANE_WIDTH-1] & ~isUnsigned}}, rtLane};
			prod = rsExt * rtExt;
			// widen each product before adding, 4 bits of headroom
			sumNext = sumNext + {{(`DOT_WIDTH-2*`LANE_WIDTH){prod[2*`LANE_WIDTH-1] & ~isUnsigned}}, prod};
		end
	end

	pipeStage #(
		.payloadT(logic [`DOT_WIDTH-1:0])
	) i_sumStage (
		.clock   (clock),
		.rst     (rst),
		.hold    (hold),
		.inValid (inValid),
		.inData  (sumNext),
		.outValid(),
		.outData (dotSum)
	);

endmodule

`default_nettype wire

// ==== design/resultFormat.sv ====
// result formatter of the packed multiply block
// picks one of five result forms and registers the output

`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module resultFormat (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  hold,
	input  logic                  cmdValid,
	input  mulCmdPkg::mulCmd      cmd,
	input  mulResultPkg::laneProd products,
	input  logic [`DOT_WIDTH-1:0] dotSum,
	output mulResultPkg::mulOut   result
);

	logic                   lowFill;
	logic                   dotFill;
	logic [`WORD_WIDTH-1:0] valueNext;
	logic                   outValidQ;
	logic [`WORD_WIDTH-1:0] outValueQ;

	// fill bits for the two widened forms
	assign lowFill = products.prod0[2*`LANE_WIDTH-1] & ~cmd.isUnsigned;
	assign dotFill = dotSum[`DOT_WIDTH-1] & ~cmd.isUnsigned;

	always_comb
	begin
		case (cmd.op)
			mulCmdPkg::opLowWord:
				valueNext = {{(`WORD_WIDTH-2*`LANE_WIDTH){lowFill}}, products.prod0};
			mulCmdPkg::opPairWord:
				valueNext = {products.prod1, products.prod0};
			// lane 3 ends up in the top 16 bits
			mulCmdPkg::opPackLow:
				valueNext = {products.prod3[`LANE_WIDTH-1:0], products.prod2[`LANE_WIDTH-1:0],
					products.prod1[`LANE_WIDTH-1:0], products.prod0[`LANE_WIDTH-1:0]};
			mulCmdPkg::opPackHigh:
				valueNext = {products.prod3[2*`LANE_WIDTH-1:`LANE_WIDTH],
					products.prod2[2*`LANE_WIDTH-1:`LANE_WIDTH],
					products.prod1[2*`LANE_WIDTH-1:`LANE_WIDTH],
					products.prod0[2*`LANE_WIDTH-1:`LANE_WIDTH]};
			mulCmdPkg::opDotSum:
				valueNext = {{(`WORD_WIDTH-`DOT_WIDTH){dotFill}}, dotSum};
			default:
				valueNext = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			outValidQ <= 1'b0;
		else if (!hold)
			outValidQ <= cmdValid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			outValueQ <= valueNext;
	end

	// a pending result is masked during hold and shows again after it
	assign result = '{valid: outValidQ & ~hold, value: outValueQ};

endmodule

`default_nettype wire

// ==== design/simdMulUnit.sv ====
// top level of the packed multiply block
// lane products, dot sum and command in stage 1, formatter in stage 2

`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module simdMulUnit (
	input  logic                clock,
	input  logic                rst,
	input  logic                hold,
	input  mulCmdPkg::mulReq    req,
	output mulResultPkg::mulOut result
);

	mulCmdPkg::mulCmd      reqCmd;
	mulCmdPkg::mulCmd      stagedCmd;
	logic                  cmdValid;
	mulResultPkg::laneProd stagedProd;
	logic [`DOT_WIDTH-1:0] stagedSum;

	assign reqCmd = '{op: req.op, isUnsigned: req.isUnsigned};

	// both data paths see the same operands on the same edge
	laneProducts i_laneProducts (
		.clock     (clock),
		.rst       (rst),
		.hold      (hold),
		.inValid   (req.valid),
		.rs        (req.rs),
		.rt        (req.rt),
		.isUnsigned(req.isUnsigned),
		.products  (stagedProd)
	);

	dotAccumulate i_dotAccumulate (
		.clock     (clock),
		.rst       (rst),
		.hold      (hold),
		.inValid   (req.valid),
		.rs        (req.rs),
		.rt        (req.rt),
		.isUnsigned(req.isUnsigned),
		.dotSum    (stagedSum)
	);

	// command stage owns the stage 1 valid
	pipeStage #(
		.payloadT(mulCmdPkg::mulCmd)
	) i_cmdStage (
		.clock   (clock),
		.rst     (rst),
		.hold    (hold),
		.inValid (req.valid),
		.inData  (reqCmd),
		.outValid(cmdValid),
		.outData (stagedCmd)
	);

	resultFormat i_resultFormat (
		.clock   (clock),
		.rst     (rst),
		.hold    (hold),
		.cmdValid(cmdValid),
		.cmd     (stagedCmd),
		.products(stagedProd),
		.dotSum  (stagedSum),
		.result  (result)
	);

endmodule

`default_nettype wire

// ==== tb/tbSimdMulTable.svh ====
// stimulus table for the packed multiply testbench
// row builder, table contents and expected-value model

`ifndef TB_SIMD_MUL_TABLE_SVH
`define TB_SIMD_MUL_TABLE_SVH

// one request, then hold cycles, then idle cycles
// rows flagged randomOps get rs and rt from $urandom
typedef struct packed
{
	logic [2:0]             op;
	logic                   isUnsigned;
	logic [`WORD_WIDTH-1:0] rs;
	logic [`WORD_WIDTH-1:0] rt;
	logic [3:0]             holdAfter;
	logic [3:0]             idleAfter;
	logic                   randomOps;
} stimRow;

localparam int TABLE_LEN = 22;

stimRow stimTable [TABLE_LEN];

function automatic stimRow makeRow(
	input logic [2:0]             op,
	input int                     uns,
	input logic [`WORD_WIDTH-1:0] rs,
	input logic [`WORD_WIDTH-1:0] rt,
	input int                     holdAfter,
	input int                     idleAfter,
	input int                     randomOps
);
	stimRow row;
	row.op = op;
	row.isUnsigned = (uns != 0);
	row.rs = rs;
	row.rt = rt;
	row.holdAfter = 4'(holdAfter);
	row.idleAfter = 4'(idleAfter);
	row.randomOps = (randomOps != 0);
	return row;
endfunction

// columns: op code, unsigned, rs, rt, hold after, idle after, random operands
// op codes 1 low word, 3 pair, 4 pack low, 5 pack high, 6 dot sum
function automatic void loadTable();
	// lone requests first, corner lanes 8000 and FFFF
	stimTable[0] = makeRow(3'd1, 0, 64'h0000000000008000, 64'h0000000000008000, 0, 3, 0);
	stimTable[1] = makeRow(3'd1, 1, 64'h000000000000FFFF, 64'h000000000000FFFF, 0, 3, 0);
	stimTable[2] = makeRow(3'd1, 0, 64'h000000000000FFFF, 64'h0000000000000003, 0, 0, 0);
	stimTable[3] = makeRow(3'd3, 0, 64'h0000000080007FFF, 64'h0000000080008000, 0, 0, 0);
	stimTable[4] = makeRow(3'd3, 1, 64'h00000000FFFF1234, 64'h00000000FFFF0010, 0, 0, 0);
	stimTable[5] = makeRow(3'd4, 0, 64'h8000FFFF7FFF0002, 64'h800000037FFFFFFE, 0, 0, 0);
	stimTable[6] = makeRow(3'd4, 1, 64'h8000FFFF7FFF0002, 64'h800000037FFFFFFE, 0, 0, 0);
	// hold lands while two results are still in flight
	stimTable[7] = makeRow(3'd5, 0, 64'h8000FFFF7FFF0002, 64'h800000037FFFFFFE, 4, 0, 0);
	stimTable[8] = makeRow(3'd5, 1, 64'hFFFF8000123400FF, 64'hFFFF800056780100, 0, 0, 0);
	stimTable[9] = makeRow(3'd6, 0, 64'h8000800080008000, 64'h8000800080008000, 0, 0, 0);
	stimTable[10] = makeRow(3'd6, 1, 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF, 0, 0, 0);
	stimTable[11] = makeRow(3'd6, 0, 64'h0001FFFF80007FFF, 64'h000200057FFF8000, 2, 0, 0);
	stimTable[12] = makeRow(3'd6, 0, 64'hFFFFFFFFFFFFFFFF, 64'h0001000100010001, 0, 1, 0);
	// unlisted codes
	stimTable[13] = makeRow(3'd0, 0, 64'h1234567890ABCDEF, 64'hFEDCBA0987654321, 0, 0, 0);
	stimTable[14] = makeRow(3'd2, 1, 64'h1234567890ABCDEF, 64'hFEDCBA0987654321, 0, 0, 0);
	stimTable[15] = makeRow(3'd7, 0, 64'h1234567890ABCDEF, 64'hFEDCBA0987654321, 0, 2, 0);
	stimTable[16] = makeRow(3'd1, 0, 64'h0, 64'h0, 0, 0, 1);
	stimTable[17] = makeRow(3'd3, 1, 64'h0, 64'h0, 1, 0, 1);
	stimTable[18] = makeRow(3'd4, 0, 64'h0, 64'h0, 0, 0, 1);
	stimTable[19] = makeRow(3'd5, 1, 64'h0, 64'h0, 3, 0, 1);
	stimTable[20] = makeRow(3'd6, 0, 64'h0, 64'h0, 0, 0, 1);
	stimTable[21] = makeRow(3'd6, 1, 64'h0, 64'h0, 0, 0, 1);
	for (int i = 0; i < TABLE_LEN; i++)
	begin
		if (stimTable[i].randomOps)
		begin
			stimTable[i].rs = {$urandom(), $urandom()};
			stimTable[i].rt = {$urandom(), $urandom()};
		end
	end
endfunction

// exact lane products in 64 bits, two's complement for signed lanes
function automatic logic [`WORD_WIDTH-1:0] expectedValue(
	input logic [2:0]             op,
	input logic                   isUnsigned,
	input logic [`WORD_WIDTH-1:0] rs,
	input logic [`WORD_WIDTH-1:0] rt
);
	logic [`WORD_WIDTH-1:0] prd [`MUL_LANES];
	logic [`WORD_WIDTH-1:0] a;
	logic [`WORD_WIDTH-1:0] b;
	logic [`WORD_WIDTH-1:0] total;
	logic [`WORD_WIDTH-1:0] value;
	logic                   aNeg;
	logic                   bNeg;
	total = '0;
	for (int k = 0; k < `MUL_LANES; k++)
	begin
		aNeg = rs[k*`LANE_WIDTH + `LANE_WIDTH-1] & ~isUnsigned;
		bNeg = rt[k*`LANE_WIDTH + `LANE_WIDTH-1] & ~isUnsigned;
		a = {{(`WORD_WIDTH-`LANE_WIDTH){aNeg}}, rs[k*`LANE_WIDTH +: `LANE_WIDTH]};
		b = {{(`WORD_WIDTH-`LANE_WIDTH){bNeg}}, rt[k*`LANE_WIDTH +: `LANE_WIDTH]};
		prd[k] = a * b;
		// the full sum always fits, so no 36-bit wrap to model
		total = total + prd[k];
	end
	case (op)
		mulCmdPkg::opLowWord:
			value = prd[0];
		mulCmdPkg::opPairWord:
			value = {prd[1][31:0], prd[0][31:0]};
		mulCmdPkg::opPackLow:
			value = {prd[3][15:0], prd[2][15:0], prd[1][15:0], prd[0][15:0]};
		mulCmdPkg::opPackHigh:
			value = {prd[3][31:16], prd[2][31:16], prd[1][31:16], prd[0][31:16]};
		mulCmdPkg::opDotSum:
			value = total;
		default:
			value = '0;
	endcase
	return value;
endfunction

`endif

// ==== tb/tbSimdMul.sv ====
// testbench for the packed multiply block
// table-driven requests with hold insertion and cycle-exact, in-order checks

`timescale 1ns/10ps
`default_nettype none

`include "mul_defs.svh"

module tbSimdMul;

	logic                clock = 1'b0;
	logic                rst;
	logic                hold;
	mulCmdPkg::mulReq    req;
	mulResultPkg::mulOut result;

	`include "tbSimdMulTable.svh"

	localparam int TIMEOUT_CYCLES = TABLE_LEN * 4 + 50;

	// expected values, oldest first
	logic [`WORD_WIDTH-1:0] expQ [$];

	// shadow of stage 1 and stage 2 valids
	logic modelStage1;
	logic modelStage2;

	int cycleCount = 0;
	int checkCount = 0;
	int valueErrors = 0;
	int validErrors = 0;
	int otherErrors = 0;

	simdMulUnit i_simdMulUnit (
		.clock (clock),
		.rst   (rst),
		.hold  (hold),
		.req   (req),
		.result(result)
	);

	always #2 clock = ~clock;

	// run limit
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles with %0d results never returned",
				cycleCount, expQ.size());
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// falling edge, then check what the last rising edge produced
	task automatic nextCycle();
		logic [`WORD_WIDTH-1:0] expValue;
		logic                   expValid;
		@(negedge clock);
		if (rst)
		begin
			modelStage1 = 1'b0;
			modelStage2 = 1'b0;
		end
		else
		begin
			// inputs still hold what that rising edge saw
			if (!hold)
			begin
				modelStage2 = modelStage1;
				modelStage1 = req.valid;
			end
			expValid = modelStage2 & ~hold;
			checkCount++;
			if (result.valid === 1'b1)
			begin
				assert (expQ.size() > 0)
				else
				begin
					otherErrors++;
					$display("unexpected result strobe at time %0t, no request was pending",
						$time);
				end
				if (expQ.size() > 0)
				begin
					expValue = expQ.pop_front();
					assert (result.value === expValue)
					else
					begin
						valueErrors++;
						$display("Mismatch at time %0t: result.value expected %h, got %h",
							$time, expValue, result.value);
					end
				end
			end
			assert (result.valid === expValid)
			else
			begin
				validErrors++;
				$display("Mismatch at time %0t: result.valid expected %b, got %b",
					$time, expValid, result.valid);
			end
		end
	endtask

	task automatic driveStrobe(input stimRow row);
		hold = 1'b0;
		req = '{valid: 1'b1, op: mulCmdPkg::mulOp'(row.op), isUnsigned: row.isUnsigned,
			rs: row.rs, rt: row.rt};
		expQ.push_back(expectedValue(row.op, row.isUnsigned, row.rs, row.rt));
	endtask

	task automatic driveIdle(input logic holdLevel);
		hold = holdLevel;
		req.valid = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h95a2cdb6));
		rst = 1'b1;
		hold = 1'b0;
		req = '0;
		modelStage1 = 1'b0;
		modelStage2 = 1'b0;
		loadTable();
		repeat (8)
		begin
			nextCycle();
		end
		rst = 1'b0;
		// quiet gap after reset, output must stay low
		repeat (3)
		begin
			nextCycle();
			driveIdle(1'b0);
		end
		for (int i = 0; i < TABLE_LEN; i++)
		begin
			nextCycle();
			driveStrobe(stimTable[i]);
			for (int h = 0; h < int'(stimTable[i].holdAfter); h++)
			begin
				nextCycle();
				driveIdle(1'b1);
			end
			for (int g = 0; g < int'(stimTable[i].idleAfter); g++)
			begin
				nextCycle();
				driveIdle(1'b0);
			end
		end
		// drain, the timeout catches a lost result
		while (expQ.size() > 0)
		begin
			nextCycle();
			driveIdle(1'b0);
		end
		repeat (4)
		begin
			nextCycle();
			driveIdle(1'b0);
		end
		$display("checks %0d, value mismatches %0d, valid mismatches %0d, other errors %0d",
			checkCount, valueErrors, validErrors, otherErrors);
		if (valueErrors + validErrors + otherErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
+incdir+tb
design/mulCmdPkg.sv
design/mulResultPkg.sv
design/pipeStage.sv
design/laneProducts.sv
design/dotAccumulate.sv
design/resultFormat.sv
design/simdMulUnit.sv
tb/tbSimdMul.sv

// ==== run.sh ====
#!/bin/sh
# build and run the packed multiply testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbSimdMul --Mdir obj_dir -f tb.f

# status is read from the log below
./obj_dir/VtbSimdMul > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log
then
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log
then
	echo "simulation ended without a status line"
	exit 1
fi
